// ==== afu_control_cases.txt ====
# source cu_id address rsp_code, all hex, source 0 is the read queue and 1 the write queue
# the first 18 lines are pushed while the link holds back responses
1 3 20000040 00
1 5 20000080 07
0 1 10000000 00
0 2 10000040 00
0 3 10000080 07
0 4 100000c0 00
0 5 10000100 00
0 6 10000140 00
0 7 10000180 07
0 8 100001c0 00
0 9 10000200 00
0 a 10000240 00
1 6 200000c0 00
1 7 20000100 07
1 8 20000140 00
1 9 20000180 00
1 b 200001c0 00
1 c 20000200 07
0 d 10000280 00
1 e 20000240 00
0 f 100002c0 07
1 0 20000280 00

// ==== afu_control.f ====
+incdir+.
afu_cmd_pkg.sv
afu_link_pkg.sv
cmd_queue_if.sv
cmd_queue.sv
cmd_arbiter.sv
tag_table.sv
afu_control.sv
afu_control_asserts.sv
tb_afu_control.sv

// ==== run_afu_control.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_afu_control
LOG_FILE=run_afu_control.log

verilator --binary --timing --assert -Wno-fatal \
	-f afu_control.f \
	--top-module tb_afu_control \
	-Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_afu_control" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG_FILE"; then
	exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1

// ==== tb_afu_control.sv ====
`default_nettype none

`include "afu_control_macros.svh"

module tb_afu_control;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 50;
	localparam int DRIVE_DELAY = 10;
	localparam int MAX_CASES   = 64;
	// Cases pushed while the link model stays silent
	localparam int HOLD_CASES  = 18;
	localparam int WAIT_LIMIT  = 400;
	localparam int QUIET_SPAN  = 20;

	logic                     clock;
	logic                     rst_n;
	logic                     read_cmd_valid;
	logic [`AFU_CU_W-1:0]     read_cmd_cu;
	logic [`AFU_ADDR_W-1:0]   read_cmd_address;
	logic                     write_cmd_valid;
	logic [`AFU_CU_W-1:0]     write_cmd_cu;
	logic [`AFU_ADDR_W-1:0]   write_cmd_address;
	logic                     read_queue_full;
	logic                     write_queue_full;
	logic                     command_valid;
	afu_cmd_pkg::cmd_opcode_e command_opcode;
	logic [`AFU_ADDR_W-1:0]   command_address;
	logic [`AFU_TAG_W-1:0]    command_tag;
	logic                     link_rsp_valid;
	logic [`AFU_TAG_W-1:0]    link_rsp_tag;
	afu_link_pkg::rsp_code_e  link_rsp_code;
	logic [`AFU_CREDIT_W-1:0] link_rsp_credits;
	logic                     read_rsp_valid;
	logic [`AFU_CU_W-1:0]     read_rsp_cu;
	logic                     write_rsp_valid;
	logic [`AFU_CU_W-1:0]     write_rsp_cu;
	afu_link_pkg::rsp_code_e  rsp_code;

	// Case table, source 1 means write queue
	logic                   case_src [MAX_CASES];
	logic [`AFU_CU_W-1:0]   case_cu [MAX_CASES];
	logic [`AFU_ADDR_W-1:0] case_addr [MAX_CASES];
	logic [7:0]             case_code [MAX_CASES];
	// Edge at which each pushed case sits in its queue
	int                     case_ready [MAX_CASES];
	int                     num_cases;

	// Per source push order, case indices
	int read_order[$];
	int write_order[$];

	// Scoreboard keyed by tag
	logic exp_busy [`AFU_TAG_COUNT];
	int   exp_case [`AFU_TAG_COUNT];

	// Link model
	logic [`AFU_TAG_W-1:0] link_tags[$];
	logic                  link_hold;
	int                    link_wait;
	int                    seed;

	// Two stage expectation line for routed responses
	logic                  pipe_valid [2];
	logic [`AFU_TAG_W-1:0] pipe_tag [2];
	int                    pipe_case [2];

	int   cycle_count;
	int   issued;
	int   responded;
	logic have_last;
	logic last_src;
	logic full_seen;
	logic timed_out;
	int   cmd_errors;
	int   rsp_errors;
	int   flow_errors;

	afu_control dut0 (.*);

	//////////////////////////////
	// Clock and edge count
	//////////////////////////////

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	//////////////////////////////
	// Link model
	//////////////////////////////

	// Answers issued tags in order after 1 to 6 cycles
	always begin
		@(posedge clock);
		#DRIVE_DELAY;
		link_rsp_valid = 1'b0;
		if (rst_n && !link_hold && link_tags.size() > 0) begin
			if (link_wait == 0)
				link_wait = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
			link_wait--;
			if (link_wait == 0) begin
				link_rsp_tag   = link_tags.pop_front();
				link_rsp_code  = afu_link_pkg::rsp_code_e'(case_code[exp_case[link_rsp_tag]]);
				link_rsp_valid = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Monitor
	//////////////////////////////

	task compare_response;
		int   idx;
		logic want_read;
		logic want_write;
		idx        = pipe_case[1];
		want_read  = pipe_valid[1] && !case_src[idx];
		want_write = pipe_valid[1] && case_src[idx];
		assert (read_rsp_valid === want_read) else begin
			rsp_errors++;
			$display("[ERROR] read_rsp_valid=%h expected %h", read_rsp_valid, want_read);
		end
		assert (write_rsp_valid === want_write) else begin
			rsp_errors++;
			$display("[ERROR] write_rsp_valid=%h expected %h", write_rsp_valid, want_write);
		end
		if (want_read) begin
			assert (read_rsp_cu == case_cu[idx]) else begin
				rsp_errors++;
				$display("[ERROR] read_rsp_cu=%h expected %h", read_rsp_cu, case_cu[idx]);
			end
		end
		if (want_write) begin
			assert (write_rsp_cu == case_cu[idx]) else begin
				rsp_errors++;
				$display("[ERROR] write_rsp_cu=%h expected %h", write_rsp_cu, case_cu[idx]);
			end
		end
		if (pipe_valid[1]) begin
			assert (rsp_code == case_code[idx]) else begin
				rsp_errors++;
				$display("[ERROR] rsp_code=%h expected %h", rsp_code, case_code[idx]);
			end
			exp_busy[pipe_tag[1]] = 1'b0;
			responded++;
		end
		// Shift, then take the response the link drives this cycle
		pipe_valid[1] = pipe_valid[0];
		pipe_tag[1]   = pipe_tag[0];
		pipe_case[1]  = pipe_case[0];
		pipe_valid[0] = link_rsp_valid;
		pipe_tag[0]   = link_rsp_tag;
		pipe_case[0]  = exp_case[link_rsp_tag];
	endtask

	task track_issue;
		int                       idx;
		logic                     src;
		logic                     matched;
		logic                     other_waiting;
		afu_cmd_pkg::cmd_opcode_e want_opcode;
		src           = 1'b0;
		matched       = 1'b1;
		other_waiting = 1'b0;
		// Source is the queue whose pending head holds this address
		if (write_order.size() > 0 && command_address == case_addr[write_order[0]])
			src = 1'b1;
		else if (read_order.size() > 0 && command_address == case_addr[read_order[0]])
			src = 1'b0;
		else
			matched = 1'b0;
		assert (matched) else begin
			cmd_errors++;
			$display("[ERROR] command_address=%h matches neither queue head", command_address);
		end
		if (!matched)
			return;
		want_opcode = src ? afu_cmd_pkg::WRITE_MI : afu_cmd_pkg::READ_CL;
		assert (command_opcode == want_opcode) else begin
			cmd_errors++;
			$display("[ERROR] command_opcode=%h expected %h", command_opcode, want_opcode);
		end
		// Other queue requested if its head was stored before this issue edge
		if (src && read_order.size() > 0)
			other_waiting = case_ready[read_order[0]] < cycle_count;
		if (!src && write_order.size() > 0)
			other_waiting = case_ready[write_order[0]] < cycle_count;
		if (other_waiting && have_last) begin
			assert (src != last_src) else begin
				flow_errors++;
				$display("Round robin failed, one queue issued twice while the other waited");
			end
		end
		last_src  = src;
		have_last = 1'b1;
		idx = src ? write_order.pop_front() : read_order.pop_front();
		assert (!exp_busy[command_tag]) else begin
			cmd_errors++;
			$display("[ERROR] command_tag=%h is still in flight", command_tag);
		end
		exp_busy[command_tag] = 1'b1;
		exp_case[command_tag] = idx;
		link_tags.push_back(command_tag);
		issued++;
	endtask

	// Outputs settle by mid-cycle
	always @(negedge clock) begin
		if (rst_n) begin
			compare_response();
			if (command_valid)
				track_issue();
			if (read_queue_full)
				full_seen = 1'b1;
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task load_cases;
		int          fd;
		int          rc;
		string       line;
		logic [31:0] f_src;
		logic [31:0] f_cu;
		logic [31:0] f_addr;
		logic [31:0] f_code;
		num_cases = 0;
		fd = $fopen("afu_control_cases.txt", "r");
		assert (fd != 0) else begin
			flow_errors++;
			$display("Could not open afu_control_cases.txt");
		end
		if (fd == 0)
			return;
		while (!$feof(fd) && num_cases < MAX_CASES) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc > 0 && line.getc(0) != "#") begin
				rc = $sscanf(line, "%h %h %h %h", f_src, f_cu, f_addr, f_code);
				if (rc == 4) begin
					case_src[num_cases]  = f_src[0];
					case_cu[num_cases]   = f_cu[`AFU_CU_W-1:0];
					case_addr[num_cases] = f_addr;
					case_code[num_cases] = f_code[7:0];
					num_cases++;
				end
			end
		end
		$fclose(fd);
	endtask

	task note_timeout(input string what);
		timed_out = 1'b1;
		flow_errors++;
		$display("Timeout while waiting for %s", what);
	endtask

	// Next edge plus drive delay, push strobes drop
	task step_cycle;
		@(posedge clock);
		#DRIVE_DELAY;
		read_cmd_valid  = 1'b0;
		write_cmd_valid = 1'b0;
	endtask

	task expect_low(input string name, input logic value);
		assert (value === 1'b0) else begin
			flow_errors++;
			$display("[ERROR] %s=%h expected 0", name, value);
		end
	endtask

	task push_case(input int idx);
		int waited;
		waited = 0;
		while (case_src[idx] ? write_queue_full : read_queue_full) begin
			if (waited >= WAIT_LIMIT) begin
				note_timeout("room in a full command queue");
				return;
			end
			step_cycle();
			waited++;
		end
		case_ready[idx] = cycle_count + 1;
		if (case_src[idx]) begin
			write_cmd_valid   = 1'b1;
			write_cmd_cu      = case_cu[idx];
			write_cmd_address = case_addr[idx];
			write_order.push_back(idx);
		end else begin
			read_cmd_valid   = 1'b1;
			read_cmd_cu      = case_cu[idx];
			read_cmd_address = case_addr[idx];
			read_order.push_back(idx);
		end
		step_cycle();
	endtask

	task run_cases;
		int idx;
		int waited;
		for (idx = 0; idx < HOLD_CASES; idx++) begin
			push_case(idx);
			if (timed_out)
				return;
		end
		waited = 0;
		while (issued < `AFU_CREDITS) begin
			if (waited >= WAIT_LIMIT) begin
				note_timeout("the first commands to issue");
				return;
			end
			step_cycle();
			waited++;
		end
		// Credits exhausted, bus must stay quiet
		repeat (QUIET_SPAN) step_cycle();
		assert (issued == `AFU_CREDITS) else begin
			flow_errors++;
			$display("%0d commands issued with responses held back, only %0d credits exist",
				issued, `AFU_CREDITS);
		end
		assert (full_seen) else begin
			flow_errors++;
			$display("Read queue never reported full while credits were withheld");
		end
		link_hold = 1'b0;
		for (idx = HOLD_CASES; idx < num_cases; idx++) begin
			push_case(idx);
			if (timed_out)
				return;
		end
		waited = 0;
		while (issued < num_cases || responded < num_cases) begin
			if (waited >= WAIT_LIMIT) begin
				note_timeout("all commands to issue and all responses to return");
				return;
			end
			step_cycle();
			waited++;
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		rst_n             = 1'b0;
		read_cmd_valid    = 1'b0;
		read_cmd_cu       = '0;
		read_cmd_address  = '0;
		write_cmd_valid   = 1'b0;
		write_cmd_cu      = '0;
		write_cmd_address = '0;
		link_rsp_valid    = 1'b0;
		link_rsp_tag      = '0;
		link_rsp_code     = afu_link_pkg::RSP_DONE;
		link_rsp_credits  = `AFU_CREDIT_W'(1);
		link_hold         = 1'b1;
		link_wait         = 0;
		seed              = 32'hc2f5_7cf1;
		cycle_count       = 0;
		issued            = 0;
		responded         = 0;
		have_last         = 1'b0;
		last_src          = 1'b0;
		full_seen         = 1'b0;
		timed_out         = 1'b0;
		cmd_errors        = 0;
		rsp_errors        = 0;
		flow_errors       = 0;
		for (int i = 0; i < 2; i++)
			pipe_valid[i] = 1'b0;
		for (int i = 0; i < `AFU_TAG_COUNT; i++) begin
			exp_busy[i] = 1'b0;
			exp_case[i] = 0;
		end
		load_cases();
		// Two reset edges
		repeat (2) @(posedge clock);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		expect_low("command_valid", command_valid);
		expect_low("read_rsp_valid", read_rsp_valid);
		expect_low("write_rsp_valid", write_rsp_valid);
		expect_low("read_queue_full", read_queue_full);
		expect_low("write_queue_full", write_queue_full);
		assert (num_cases > HOLD_CASES) else begin
			flow_errors++;
			$display("Case file holds %0d cases, more than %0d are needed", num_cases, HOLD_CASES);
		end
		if (num_cases > HOLD_CASES)
			run_cases();
		$display("Errors: command %0d, response %0d, flow %0d", cmd_errors, rsp_errors, flow_errors);
		if (!timed_out && cmd_errors == 0 && rsp_errors == 0 && flow_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== afu_control_asserts.sv ====
`default_nettype none

`include "afu_control_macros.svh"

module afu_control_asserts (
	input logic                      clock,
	input logic                      rst_n,
	input logic [`AFU_CREDIT_W-1:0]  credits,
	input logic [`AFU_TAG_COUNT-1:0] busy_vec,
	input logic                      command_valid,
	input logic [`AFU_TAG_W-1:0]     command_tag,
	input logic                      link_rsp_valid,
	input logic [`AFU_CREDIT_W-1:0]  link_rsp_credits
);

	timeunit 1ns;
	timeprecision 100ps;

	// Link side view of the credit pool
	logic [`AFU_CREDIT_W-1:0] link_credits;

	// Bus commands take one, link responses give theirs back
	always_ff @(posedge clock) begin
		if (!rst_n)
			link_credits <= `AFU_CREDIT_W'(`AFU_CREDITS);
		else
			link_credits <= link_credits - `AFU_CREDIT_W'(command_valid)
				+ (link_rsp_valid ? link_rsp_credits : '0);
	end

	// Counter never exceeds the pool granted at reset
	credit_bound: assert property (@(posedge clock) disable iff (!rst_n)
		credits <= `AFU_CREDIT_W'(`AFU_CREDITS))
		else $error("credit counter above its reset value");

	// Bus tag idle before the alloc edge, held busy after it
	tag_idle: assert property (@(posedge clock) disable iff (!rst_n)
		command_valid |-> busy_vec[command_tag] &&
			(($past(busy_vec) & (`AFU_TAG_COUNT'(1) << command_tag)) == '0))
		else $error("issued tag was already busy or was not marked busy");

	// A bus command needs a credit the link still owes
	credit_issue: assert property (@(posedge clock) disable iff (!rst_n)
		command_valid |-> (link_credits != '0))
		else $error("command issued while the link had no credits left");

endmodule

// Tap arbiter credits and tag occupancy inside the top level
bind afu_control afu_control_asserts asserts0 (
	.clock            (clock),
	.rst_n            (rst_n),
	.credits          (arbiter0.credits),
	.busy_vec         (tag_table0.busy_vec),
	.command_valid    (command_valid),
	.command_tag      (command_tag),
	.link_rsp_valid   (link_rsp_valid),
	.link_rsp_credits (link_rsp_credits)
);

`default_nettype wire

// ==== afu_control.sv ====
`default_nettype none

`include "afu_control_macros.svh"

module afu_control (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       read_cmd_valid,
	input  logic [`AFU_CU_W-1:0]       read_cmd_cu,
	input  logic [`AFU_ADDR_W-1:0]     read_cmd_address,
	input  logic                       write_cmd_valid,
	input  logic [`AFU_CU_W-1:0]       write_cmd_cu,
	input  logic [`AFU_ADDR_W-1:0]     write_cmd_address,
	output logic                       read_queue_full,
	output logic                       write_queue_full,
	output logic                       command_valid,
	output afu_cmd_pkg::cmd_opcode_e   command_opcode,
	output logic [`AFU_ADDR_W-1:0]     command_address,
	output logic [`AFU_TAG_W-1:0]      command_tag,
	input  logic                       link_rsp_valid,
	input  logic [`AFU_TAG_W-1:0]      link_rsp_tag,
	input  afu_link_pkg::rsp_code_e    link_rsp_code,
	input  logic [`AFU_CREDIT_W-1:0]   link_rsp_credits,
	output logic                       read_rsp_valid,
	output logic [`AFU_CU_W-1:0]       read_rsp_cu,
	output logic                       write_rsp_valid,
	output logic [`AFU_CU_W-1:0]       write_rsp_cu,
	output afu_link_pkg::rsp_code_e    rsp_code
);

	afu_link_pkg::link_rsp_t rsp_latched;

	logic                     alloc;
	afu_cmd_pkg::cmd_source_e alloc_source;
	logic [`AFU_CU_W-1:0]     alloc_cu;
	logic [`AFU_TAG_W-1:0]    free_tag;
	logic                     tag_ready;
	logic [`AFU_CREDIT_W-1:0] credit_return;

	cmd_queue_if read_if0 (.clock(clock));
	cmd_queue_if write_if0 (.clock(clock));

	//////////////////////////////
	// Link input latch
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rsp_latched.valid <= 1'b0;
		end else begin
			rsp_latched.valid   <= link_rsp_valid;
			rsp_latched.tag     <= link_rsp_tag;
			rsp_latched.code    <= link_rsp_code;
			rsp_latched.credits <= link_rsp_credits;
		end
	end

	//////////////////////////////
	// Command queues
	//////////////////////////////

	cmd_queue #(.OPCODE(afu_cmd_pkg::READ_CL)) read_queue0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.push    (read_cmd_valid),
		.cu      (read_cmd_cu),
		.address (read_cmd_address),
		.full    (read_queue_full),
		.port    (read_if0.queue)
	);

	cmd_queue #(.OPCODE(afu_cmd_pkg::WRITE_MI)) write_queue0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.push    (write_cmd_valid),
		.cu      (write_cmd_cu),
		.address (write_cmd_address),
		.full    (write_queue_full),
		.port    (write_if0.queue)
	);

	//////////////////////////////
	// Arbiter and tags
	//////////////////////////////

	cmd_arbiter arbiter0 (
		.clock           (clock),
		.rst_n           (rst_n),
		.read_port       (read_if0.arbiter),
		.write_port      (write_if0.arbiter),
		.tag_ready       (tag_ready),
		.free_tag        (free_tag),
		.credit_return   (credit_return),
		.alloc           (alloc),
		.alloc_source    (alloc_source),
		.alloc_cu        (alloc_cu),
		.command_valid   (command_valid),
		.command_opcode  (command_opcode),
		.command_address (command_address),
		.command_tag     (command_tag)
	);

	tag_table tag_table0 (
		.clock           (clock),
		.rst_n           (rst_n),
		.alloc           (alloc),
		.alloc_source    (alloc_source),
		.alloc_cu        (alloc_cu),
		.rsp             (rsp_latched),
		.free_tag        (free_tag),
		.tag_ready       (tag_ready),
		.credit_return   (credit_return),
		.read_rsp_valid  (read_rsp_valid),
		.read_rsp_cu     (read_rsp_cu),
		.write_rsp_valid (write_rsp_valid),
		.write_rsp_cu    (write_rsp_cu),
		.rsp_code        (rsp_code)
	);

endmodule

`default_nettype wire

// ==== tag_table.sv ====
`default_nettype none

`include "afu_control_macros.svh"

module tag_table (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       alloc,
	input  afu_cmd_pkg::cmd_source_e   alloc_source,
	input  logic [`AFU_CU_W-1:0]       alloc_cu,
	input  afu_link_pkg::link_rsp_t    rsp,
	output logic [`AFU_TAG_W-1:0]      free_tag,
	output logic                       tag_ready,
	output logic [`AFU_CREDIT_W-1:0]   credit_return,
	output logic                       read_rsp_valid,
	output logic [`AFU_CU_W-1:0]       read_rsp_cu,
	output logic                       write_rsp_valid,
	output logic [`AFU_CU_W-1:0]       write_rsp_cu,
	output afu_link_pkg::rsp_code_e    rsp_code
);

	afu_link_pkg::tag_entry_t entries [`AFU_TAG_COUNT];

	logic [`AFU_TAG_COUNT-1:0] busy_vec;
	afu_link_pkg::tag_entry_t  hit;

	//////////////////////////////
	// Free tag search
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < `AFU_TAG_COUNT; i++)
			busy_vec[i] = entries[i].busy;
	end

	// Lowest free index wins
	always_comb begin
		free_tag = '0;
		for (int i = `AFU_TAG_COUNT - 1; i >= 0; i--) begin
			if (!busy_vec[i])
				free_tag = `AFU_TAG_W'(i);
		end
	end

	assign tag_ready = ~&busy_vec;

	//////////////////////////////
	// Table update
	//////////////////////////////

	// Freed and allocated tags never collide
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `AFU_TAG_COUNT; i++)
				entries[i].busy <= 1'b0;
		end else begin
			if (rsp.valid)
				entries[rsp.tag].busy <= 1'b0;
			if (alloc)
				entries[free_tag] <= '{busy: 1'b1, source: alloc_source, cu_id: alloc_cu};
		end
	end

	//////////////////////////////
	// Response routing
	//////////////////////////////

	assign hit = entries[rsp.tag];

	// Credits go back at the lookup edge
	assign credit_return = rsp.valid ? rsp.credits : '0;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			read_rsp_valid  <= 1'b0;
			write_rsp_valid <= 1'b0;
		end else begin
			read_rsp_valid  <= rsp.valid && hit.busy && (hit.source == afu_cmd_pkg::SRC_READ);
			write_rsp_valid <= rsp.valid && hit.busy && (hit.source == afu_cmd_pkg::SRC_WRITE);
		end
	end

	// Stored owner and link code
	always_ff @(posedge clock) begin
		if (rsp.valid) begin
			read_rsp_cu  <= hit.cu_id;
			write_rsp_cu <= hit.cu_id;
			rsp_code     <= rsp.code;
		end
	end

endmodule

`default_nettype wire

// ==== cmd_arbiter.sv ====
`default_nettype none

`include "afu_control_macros.svh"

module cmd_arbiter (
	input  logic                       clock,
	input  logic                       rst_n,
	cmd_queue_if.arbiter               read_port,
	cmd_queue_if.arbiter               write_port,
	input  logic                       tag_ready,
	input  logic [`AFU_TAG_W-1:0]      free_tag,
	input  logic [`AFU_CREDIT_W-1:0]   credit_return,
	output logic                       alloc,
	output afu_cmd_pkg::cmd_source_e   alloc_source,
	output logic [`AFU_CU_W-1:0]       alloc_cu,
	output logic                       command_valid,
	output afu_cmd_pkg::cmd_opcode_e   command_opcode,
	output logic [`AFU_ADDR_W-1:0]     command_address,
	output logic [`AFU_TAG_W-1:0]      command_tag
);

	// Write queue wins the next tie
	logic                     prio_write;
	logic [`AFU_CREDIT_W-1:0] credits;
	logic                     can_issue;
	logic                     pick_write;
	logic                     issue;
	afu_cmd_pkg::cmd_line_t   win_head;

	//////////////////////////////
	// Round robin grant
	//////////////////////////////

	// Needs a credit and a free tag
	assign can_issue = tag_ready && (credits != '0);

	always_comb begin
		if (read_port.request && write_port.request)
			pick_write = prio_write;
		else
			pick_write = write_port.request;
	end

	assign read_port.grant  = can_issue && read_port.request && !pick_write;
	assign write_port.grant = can_issue && write_port.request && pick_write;
	assign issue            = read_port.grant || write_port.grant;

	assign win_head = pick_write ? write_port.head : read_port.head;

	// Flip priority after every issue
	always_ff @(posedge clock) begin
		if (!rst_n)
			prio_write <= 1'b0;
		else if (issue)
			prio_write <= !pick_write;
	end

	//////////////////////////////
	// Credits
	//////////////////////////////

	// One credit per issue, returns added each cycle
	always_ff @(posedge clock) begin
		if (!rst_n)
			credits <= `AFU_CREDIT_W'(`AFU_CREDITS);
		else
			credits <= credits - `AFU_CREDIT_W'(issue) + credit_return;
	end

	//////////////////////////////
	// Tag allocation
	//////////////////////////////

	assign alloc        = issue;
	assign alloc_source = pick_write ? write_port.source : read_port.source;
	assign alloc_cu     = win_head.cu_id;

	//////////////////////////////
	// Command bus
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n)
			command_valid <= 1'b0;
		else
			command_valid <= issue;
	end

	// Payload of the granted head
	always_ff @(posedge clock) begin
		if (issue) begin
			command_opcode  <= win_head.opcode;
			command_address <= win_head.address;
			command_tag     <= free_tag;
		end
	end

endmodule

`default_nettype wire

// ==== cmd_queue.sv ====
`default_nettype none

`include "afu_control_macros.svh"

module cmd_queue #(
	parameter afu_cmd_pkg::cmd_opcode_e OPCODE = afu_cmd_pkg::READ_CL
) (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   push,
	input  logic [`AFU_CU_W-1:0]   cu,
	input  logic [`AFU_ADDR_W-1:0] address,
	output logic                   full,
	cmd_queue_if.queue             port
);

	localparam int PTR_W = $clog2(`AFU_QUEUE_DEPTH);

	afu_cmd_pkg::cmd_line_t entries [`AFU_QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	//////////////////////////////
	// Push and pop
	//////////////////////////////

	// Push while full is lost
	assign full    = (count == (PTR_W + 1)'(`AFU_QUEUE_DEPTH));
	assign do_push = push && !full;
	assign do_pop  = port.grant && (count != '0);

	// Storage, opcode fixed per queue
	always_ff @(posedge clock) begin
		if (do_push) begin
			entries[wr_ptr] <= '{valid: 1'b1, cu_id: cu, address: address, opcode: OPCODE};
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////
	// Arbiter side
	//////////////////////////////

	assign port.request = (count != '0);
	assign port.source  = (OPCODE == afu_cmd_pkg::WRITE_MI) ?
		afu_cmd_pkg::SRC_WRITE : afu_cmd_pkg::SRC_READ;

	// Head entry, valid follows occupancy
	always_comb begin
		port.head       = entries[rd_ptr];
		port.head.valid = port.request;
	end

endmodule

`default_nettype wire

// ==== cmd_queue_if.sv ====
`default_nettype none

// Link between one command queue and the arbiter
interface cmd_queue_if (
	input logic clock
);

	// Queue holds at least one command
	logic request;
	// Command at the queue head
	afu_cmd_pkg::cmd_line_t head;
	// Fixed source of this queue
	afu_cmd_pkg::cmd_source_e source;
	// One cycle pop strobe from the arbiter
	logic grant;

	modport queue (
		input  clock, grant,
		output request, head, source
	);

	modport arbiter (
		input  clock, request, head, source,
		output grant
	);

endinterface

`default_nettype wire

// ==== afu_link_pkg.sv ====
`default_nettype none

`include "afu_control_macros.svh"

package afu_link_pkg;

	// Response codes returned by the link
	typedef enum logic [7:0] {
		RSP_DONE  = 8'h00,
		RSP_FAULT = 8'h07
	} rsp_code_e;

	// One response after the input latch
	typedef struct packed {
		logic                     valid;
		logic [`AFU_TAG_W-1:0]    tag;
		rsp_code_e                code;
		logic [`AFU_CREDIT_W-1:0] credits;
	} link_rsp_t;

	// Owner record kept per tag
	typedef struct packed {
		logic                     busy;
		afu_cmd_pkg::cmd_source_e source;
		logic [`AFU_CU_W-1:0]     cu_id;
	} tag_entry_t;

endpackage

`default_nettype wire

// ==== afu_cmd_pkg.sv ====
`default_nettype none

`include "afu_control_macros.svh"

package afu_cmd_pkg;

	//////////////////////////////
	// Command opcodes
	//////////////////////////////

	// Link opcode codes as seen on the bus
	typedef enum logic [7:0] {
		READ_CL  = 8'h0A,
		WRITE_MI = 8'h0D
	} cmd_opcode_e;

	// Which queue a command came from
	typedef enum logic {
		SRC_READ  = 1'b0,
		SRC_WRITE = 1'b1
	} cmd_source_e;

	//////////////////////////////
	// Command line
	//////////////////////////////

	typedef struct packed {
		logic                   valid;
		logic [`AFU_CU_W-1:0]   cu_id;
		logic [`AFU_ADDR_W-1:0] address;
		cmd_opcode_e            opcode;
	} cmd_line_t;

endpackage

`default_nettype wire

// ==== afu_control_macros.svh ====
`ifndef AFU_CONTROL_MACROS_SVH
`define AFU_CONTROL_MACROS_SVH

//////////////////////////////
// Tag pool
//////////////////////////////

// Tags in flight on the link
`define AFU_TAG_COUNT 8
`define AFU_TAG_W 3

//////////////////////////////
// Queues and credits
//////////////////////////////

// Entries per command queue, power of two
`define AFU_QUEUE_DEPTH 8
// Credits granted by the link after reset
`define AFU_CREDITS 4
`define AFU_CREDIT_W 4

//////////////////////////////
// Field widths
//////////////////////////////

`define AFU_ADDR_W 32
`define AFU_CU_W 4

`endif
